//--- hw/wr_tlp_cfg.svh
// Build-time sizes and options shared by the write TLP generator.
// Included by the package and by every module that sizes a port from a macro.

`ifndef WR_TLP_CFG_SVH
`define WR_TLP_CFG_SVH

// Width of the request tag that comes back in the write response
`define WR_TLP_TAG_W 8

// Width of the line address carried on the start beat of a packet
`define WR_TLP_ADDR_W 42

// Line count field width
// A packet of 1 to 4 lines is encoded as the count minus one
`define WR_TLP_LCNT_W 2

// Payload carried by each request beat and each TLP beat
`define WR_TLP_DATA_W 64

// One beat moves one line, so a line is the payload width in bytes
`define WR_TLP_LINE_BYTES (`WR_TLP_DATA_W / 8)

// Header addressing mode
// Set to 1 to emit 32-bit memory-write headers; 0 emits 64-bit headers
`define WR_TLP_ADDR32 0

`endif

//--- hw/wr_tlp_pkg.sv
// Request, response and TLP header types for the write TLP generator.
// Modules pull these in with a wildcard import in their header.

`include "wr_tlp_cfg.svh"

package wr_tlp_pkg;

    // One request beat from the accelerator
    // The tag, line count and address are only meaningful on a start beat
    typedef struct packed {
        logic                          sop;
        logic                          eop;
        logic                          is_fence;
        logic [`WR_TLP_TAG_W-1:0]      tag;
        logic [`WR_TLP_LCNT_W-1:0]     line_count;
        logic [`WR_TLP_ADDR_W-1:0]     addr;
        logic [`WR_TLP_DATA_W-1:0]     payload;
    } wr_req_t;

    // One write response, returned per completed packet or per fence
    typedef struct packed {
        logic [`WR_TLP_TAG_W-1:0]      tag;
        logic                          is_fence;
    } wr_rsp_t;

    // Reduced memory-write header, packed into one 64-bit word
    // The address is in dwords; addr_hi is left at zero for 32-bit headers
    typedef struct packed {
        logic [7:0]                    fmttype;
        logic [9:0]                    length;
        logic [3:0]                    first_be;
        logic [3:0]                    last_be;
        logic [7:0]                    addr_hi;
        logic [29:0]                   addr_lo;
    } tlp_hdr_t;

    // Format and type byte for a memory write with a 3 or 4 dword header
    localparam logic [7:0] FMT_MWR32 = 8'h40;
    localparam logic [7:0] FMT_MWR64 = 8'h60;

    // Converts the encoded line count into the header length in dwords
    function automatic logic [9:0] line_count_to_dw_len(
        input logic [`WR_TLP_LCNT_W-1:0] line_count
    );
        logic [9:0] lines;
        lines = 10'(line_count) + 10'd1;
        return 10'(lines * (`WR_TLP_LINE_BYTES / 4));
    endfunction

endpackage

//--- hw/req_fifo2.sv
// Two-slot FIFO with the head word visible on first while not_empty is high.
// Holds request beats at the input and write responses at the output.

`timescale 1ns/1ps

module req_fifo2 #(
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              reset_n,

    input  logic [DATA_W-1:0] enq_data,
    input  logic              enq_en,
    output logic              not_full,

    output logic [DATA_W-1:0] first,
    input  logic              deq_en,
    output logic              not_empty
);

    // Slot 0 is always the head and slot 1 the word behind it
    logic [DATA_W-1:0] slot0_data;
    logic [DATA_W-1:0] slot1_data;
    logic              slot0_valid;
    logic              slot1_valid;

    // A dequeue only counts when there is a word to take
    logic              do_deq;

    assign do_deq = deq_en && slot0_valid;

    assign first     = slot0_data;
    assign not_empty = slot0_valid;
    assign not_full  = !slot1_valid;

    // Occupancy flags
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            slot0_valid <= 1'b0;
            slot1_valid <= 1'b0;
        end
        else
        begin
            // The head stays valid if something is behind it or arrives now
            if (do_deq)
            begin
                slot0_valid <= slot1_valid || enq_en;
                slot1_valid <= slot1_valid && enq_en;
            end
            else if (enq_en)
            begin
                slot0_valid <= 1'b1;
                slot1_valid <= slot0_valid;
            end
        end
    end

    // Data moves forward on a dequeue and new words land in the first free slot
    always_ff @(posedge clk)
    begin
        if (do_deq)
        begin
            slot0_data <= slot1_valid ? slot1_data : enq_data;
            slot1_data <= enq_data;
        end
        else if (enq_en)
        begin
            if (slot0_valid)
                slot1_data <= enq_data;
            else
                slot0_data <= enq_data;
        end
    end

endmodule

//--- hw/wr_hdr_builder.sv
// Builds the memory-write header from the head request beat.
// The header and tag are held across the rest of the packet after the start beat.

`timescale 1ns/1ps

`include "wr_tlp_cfg.svh"

module wr_hdr_builder
    import wr_tlp_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,

    input  wr_req_t                   head,
    input  logic                      capture,

    output tlp_hdr_t                  hdr,
    output logic [`WR_TLP_TAG_W-1:0]  tag
);

    // Header addressing mode, fixed at build time
    localparam bit ADDR32 = (`WR_TLP_ADDR32 != 0);

    tlp_hdr_t                  live_hdr;
    tlp_hdr_t                  held_hdr;
    logic [`WR_TLP_TAG_W-1:0]  held_tag;

    // Line address scaled to a dword address, one line being several dwords
    logic [37:0]               dw_addr;

    // A fence also carries its own tag, so it counts as a start beat here
    logic                      start;

    assign start   = head.sop || head.is_fence;
    assign dw_addr = 38'(head.addr * (`WR_TLP_LINE_BYTES / 4));

    // Header as it would be sent for the head beat if it starts a packet
    always_comb
    begin
        live_hdr          = '0;
        live_hdr.fmttype  = ADDR32 ? FMT_MWR32 : FMT_MWR64;
        live_hdr.length   = line_count_to_dw_len(head.line_count);
        // Whole lines are always written
        live_hdr.first_be = 4'b1111;
        live_hdr.last_be  = 4'b1111;
        // The upper dword address bits only exist in a 64-bit header
        live_hdr.addr_hi  = ADDR32 ? 8'h00 : dw_addr[37:30];
        live_hdr.addr_lo  = dw_addr[29:0];
    end

    // Keep the start beat's header and tag for the continuation beats
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            held_hdr <= '0;
            held_tag <= '0;
        end
        else if (capture)
        begin
            held_hdr <= live_hdr;
            held_tag <= head.tag;
        end
    end

    // Continuation beats do not carry a valid header of their own
    assign hdr = start ? live_hdr : held_hdr;
    assign tag = start ? head.tag : held_tag;

endmodule

//--- hw/wr_beat_counter.sv
// Tracks how many beats of the current write packet are still to come.
// Loaded on the start beat, stepped on every later beat.

`timescale 1ns/1ps

`include "wr_tlp_cfg.svh"

module wr_beat_counter (
    input  logic                       clk,
    input  logic                       reset_n,

    input  logic                       load,
    input  logic [`WR_TLP_LCNT_W-1:0]  line_count,
    input  logic                       step,

    output logic                       last_beat
);

    // Beats left in the packet counting the one at the FIFO head
    // The start beat is consumed by the load, so this never exceeds 3
    logic [`WR_TLP_LCNT_W-1:0] remaining;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            remaining <= '0;
        end
        else if (load)
        begin
            // line_count is the packet length minus one, which is exactly
            // the number of beats that follow the start beat
            remaining <= line_count;
        end
        else if (step && (remaining != '0))
        begin
            // Saturate at zero when a packet runs long
            remaining <= remaining - 1'b1;
        end
    end

    // On the start beat the answer comes straight from the encoded count
    assign last_beat = load ? (line_count == '0)
                            : (remaining == `WR_TLP_LCNT_W'(1));

endmodule

//--- hw/wr_pkt_ctrl.sv
// Packet FSM for the write TLP generator.
// Decides when the head beat moves, whether it is sent, and checks packet framing.

`timescale 1ns/1ps

module wr_pkt_ctrl
    import wr_tlp_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,

    // Head of the request FIFO
    input  wr_req_t head,
    input  logic    head_valid,
    output logic    deq,

    // Room downstream
    input  logic    out_free,
    input  logic    rsp_not_full,
    output logic    rsp_enq,

    // Strobes to the output stage, header builder and beat counter
    output logic    emit,
    output logic    capture,
    output logic    load,
    output logic    step,
    input  logic    last_beat,

    output logic    error
);

    typedef enum logic {
        IDLE,
        IN_PKT
    } state_t;

    state_t state;
    state_t state_next;

    // Framing faults seen on the beat being dequeued
    logic mid_start;
    logic stray_beat;
    logic len_bad;
    logic err_now;

    // A beat only moves when the output register and response FIFO can both take it
    // Checking the response FIFO on every beat keeps the logic simple
    assign deq = head_valid && out_free && rsp_not_full;

    // Fences are consumed here and never reach the TLP stream
    assign emit    = deq && !head.is_fence;
    assign capture = emit && head.sop;
    assign load    = capture;
    assign step    = emit && !head.sop;

    // One response per packet on its last beat, and one per fence
    assign rsp_enq = deq && (head.eop || head.is_fence);

    always_comb
    begin
        // A new packet or fence must not start inside a packet
        mid_start  = (head.sop || head.is_fence) && (state == IN_PKT);
        // A continuation beat with no packet open
        stray_beat = !head.sop && !head.is_fence && (state == IDLE);
        // eop has to land exactly on the beat the line count predicts
        len_bad    = !head.is_fence && (head.eop != last_beat);
        err_now    = deq && (mid_start || stray_beat || len_bad);
    end

    // The state follows the sop and eop markers even when framing is wrong
    // so a bad packet does not block the ones behind it
    always_comb
    begin
        state_next = state;
        if (emit)
        begin
            state_next = head.eop ? IDLE : IN_PKT;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= IDLE;
            error <= 1'b0;
        end
        else
        begin
            state <= state_next;
            // Sticky until the next reset
            if (err_now)
            begin
                error <= 1'b1;
            end
        end
    end

endmodule

//--- hw/wr_tlp_gen_top.sv
// Top level of the write TLP generator.
// Accelerator write beats go in, memory-write TLP beats and write responses come out.

`timescale 1ns/1ps

`include "wr_tlp_cfg.svh"

module wr_tlp_gen_top
    import wr_tlp_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset_n,

    // Write requests from the accelerator
    input  logic                       req_valid,
    output logic                       req_ready,
    input  wr_req_t                    req_data,

    // TLP stream to the host link, one beat per request beat
    output logic                       tlp_valid,
    input  logic                       tlp_ready,
    output logic                       tlp_sop,
    output logic                       tlp_eop,
    output tlp_hdr_t                   tlp_hdr,
    output logic [`WR_TLP_DATA_W-1:0]  tlp_payload,

    // Write responses back to the accelerator
    output logic                       rsp_valid,
    input  logic                       rsp_ready,
    output wr_rsp_t                    rsp_data,

    output logic                       error
);

    wr_req_t                   head;
    logic                      head_valid;
    logic                      deq;
    logic                      out_free;
    logic                      rsp_not_full;
    logic                      rsp_enq;
    wr_rsp_t                   rsp_word;
    logic                      emit;
    logic                      capture;
    logic                      load;
    logic                      step;
    logic                      last_beat;
    tlp_hdr_t                  cur_hdr;
    logic [`WR_TLP_TAG_W-1:0]  cur_tag;

    // Input buffer, so req_ready only depends on FIFO occupancy
    req_fifo2 #(
        .DATA_W($bits(wr_req_t))
    ) req_fifo (
        .clk,
        .reset_n,
        .enq_data  (req_data),
        .enq_en    (req_valid && req_ready),
        .not_full  (req_ready),
        .first     (head),
        .deq_en    (deq),
        .not_empty (head_valid)
    );

    wr_hdr_builder hdr_builder (
        .clk,
        .reset_n,
        .head    (head),
        .capture (capture),
        .hdr     (cur_hdr),
        .tag     (cur_tag)
    );

    wr_beat_counter beat_counter (
        .clk,
        .reset_n,
        .load       (load),
        .line_count (head.line_count),
        .step       (step),
        .last_beat  (last_beat)
    );

    // Output register can take a new beat when it is empty or being drained
    assign out_free = tlp_ready || !tlp_valid;

    wr_pkt_ctrl pkt_ctrl (
        .clk,
        .reset_n,
        .head         (head),
        .head_valid   (head_valid),
        .deq          (deq),
        .out_free     (out_free),
        .rsp_not_full (rsp_not_full),
        .rsp_enq      (rsp_enq),
        .emit         (emit),
        .capture      (capture),
        .load         (load),
        .step         (step),
        .last_beat    (last_beat),
        .error        (error)
    );

    // Response tag comes from the held packet tag, or the fence's own tag
    assign rsp_word.tag      = cur_tag;
    assign rsp_word.is_fence = head.is_fence;

    req_fifo2 #(
        .DATA_W($bits(wr_rsp_t))
    ) rsp_fifo (
        .clk,
        .reset_n,
        .enq_data  (rsp_word),
        .enq_en    (rsp_enq),
        .not_full  (rsp_not_full),
        .first     (rsp_data),
        .deq_en    (rsp_valid && rsp_ready),
        .not_empty (rsp_valid)
    );

    // Valid advances whenever the register is free, so it drops after a drained beat
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            tlp_valid <= 1'b0;
        else if (out_free)
            tlp_valid <= emit;
    end

    // Beat contents only change when a new beat is actually sent
    always_ff @(posedge clk)
    begin
        if (emit)
        begin
            tlp_sop     <= head.sop;
            tlp_eop     <= head.eop;
            tlp_hdr     <= cur_hdr;
            tlp_payload <= head.payload;
        end
    end

endmodule

//--- tb/wr_tlp_gen_tb_table.svh
// Request beats for the write TLP generator testbench, applied in table order.
// Columns of add_row: sop, eop, fence, tag, line count minus one, line address,
// payload, header length in dwords expected on a start beat (0 where unused).

`ifndef WR_TLP_GEN_TB_TABLE_SVH
`define WR_TLP_GEN_TB_TABLE_SVH

typedef struct {
    logic                      sop;
    logic                      eop;
    logic                      fence;
    logic [`WR_TLP_TAG_W-1:0]  tag;
    logic [`WR_TLP_LCNT_W-1:0] lcnt;
    logic [`WR_TLP_ADDR_W-1:0] addr;
    logic [`WR_TLP_DATA_W-1:0] payload;
    logic [9:0]                exp_len;
} table_row_t;

table_row_t rows[$];

task automatic add_row(
    input logic                      sop,
    input logic                      eop,
    input logic                      fence,
    input logic [`WR_TLP_TAG_W-1:0]  tag,
    input logic [`WR_TLP_LCNT_W-1:0] lcnt,
    input logic [`WR_TLP_ADDR_W-1:0] addr,
    input logic [`WR_TLP_DATA_W-1:0] payload,
    input logic [9:0]                exp_len
);
    table_row_t r;
    r.sop     = sop;
    r.eop     = eop;
    r.fence   = fence;
    r.tag     = tag;
    r.lcnt    = lcnt;
    r.addr    = addr;
    r.payload = payload;
    r.exp_len = exp_len;
    rows.push_back(r);
endtask

task automatic fill_table();
    // Four-line write whose dword address needs the upper header bits
    add_row(1'b1, 1'b0, 1'b0, 8'h11, 2'd3, 42'h00_8765_4321, 64'h0123_4567_89ab_0001, 10'd8);
    add_row(1'b0, 1'b0, 1'b0, 8'h00, 2'd0, 42'h0,           64'h0123_4567_89ab_0002, 10'd0);
    add_row(1'b0, 1'b0, 1'b0, 8'h00, 2'd0, 42'h0,           64'h0123_4567_89ab_0003, 10'd0);
    add_row(1'b0, 1'b1, 1'b0, 8'h00, 2'd0, 42'h0,           64'h0123_4567_89ab_0004, 10'd0);
    // Single-beat write, then a fence that must answer in order
    add_row(1'b1, 1'b1, 1'b0, 8'h22, 2'd0, 42'h00_0000_0100, 64'hfeed_0000_0000_0022, 10'd2);
    add_row(1'b1, 1'b1, 1'b1, 8'h33, 2'd0, 42'h0,           64'h0,                   10'd0);
    add_row(1'b1, 1'b0, 1'b0, 8'h44, 2'd1, 42'h02_0000_0040, 64'hcafe_0000_0000_0441, 10'd4);
    add_row(1'b0, 1'b1, 1'b0, 8'h00, 2'd0, 42'h0,           64'hcafe_0000_0000_0442, 10'd0);
    add_row(1'b1, 1'b1, 1'b1, 8'h55, 2'd0, 42'h0,           64'h0,                   10'd0);
    // Three lines announced but eop arrives on the second beat
    add_row(1'b1, 1'b0, 1'b0, 8'h66, 2'd2, 42'h00_0000_0300, 64'hbad0_0000_0000_0661, 10'd6);
    add_row(1'b0, 1'b1, 1'b0, 8'h00, 2'd0, 42'h0,           64'hbad0_0000_0000_0662, 10'd0);
    // Well formed packets after the fault, error has to stay set
    add_row(1'b1, 1'b1, 1'b0, 8'h77, 2'd0, 42'h00_0000_0400, 64'h7777_0000_0000_0771, 10'd2);
    add_row(1'b1, 1'b0, 1'b0, 8'h88, 2'd1, 42'h00_0001_0000, 64'h8888_0000_0000_0881, 10'd4);
    add_row(1'b0, 1'b1, 1'b0, 8'h00, 2'd0, 42'h0,           64'h8888_0000_0000_0882, 10'd0);
endtask

`endif

//--- tb/wr_tlp_gen_tb.sv
// Testbench for the write TLP generator.
// Walks the request table under random back-pressure and checks TLP beats, responses and error.

`timescale 1ns/1ps

`include "wr_tlp_cfg.svh"

module wr_tlp_gen_tb
    import wr_tlp_pkg::*;
();

    localparam int RESET_CYCLES   = 16;
    localparam int CYCLES_PER_ROW = 20;

    logic                      clk;
    logic                      reset_n;
    logic                      req_valid;
    logic                      req_ready;
    wr_req_t                   req_data;
    logic                      tlp_valid;
    logic                      tlp_ready;
    logic                      tlp_sop;
    logic                      tlp_eop;
    tlp_hdr_t                  tlp_hdr;
    logic [`WR_TLP_DATA_W-1:0] tlp_payload;
    logic                      rsp_valid;
    logic                      rsp_ready;
    wr_rsp_t                   rsp_data;
    logic                      error;

    // One expected TLP beat, with the error level it should see when it leaves
    typedef struct packed {
        logic                      sop;
        logic                      eop;
        logic [63:0]               hdr;
        logic [`WR_TLP_DATA_W-1:0] payload;
        logic                      err;
    } exp_tlp_t;

    exp_tlp_t    exp_tlp_q[$];
    wr_rsp_t     exp_rsp_q[$];
    int          checks;
    int          mismatches;
    int          other_errors;
    int          cycles;
    int          cycle_limit;
    logic [31:0] lfsr;
    logic        running;

    `include "wr_tlp_gen_tb_table.svh"

    wr_tlp_gen_top i_wr_tlp_gen_top (
        .clk,
        .reset_n,
        .req_valid,
        .req_ready,
        .req_data,
        .tlp_valid,
        .tlp_ready,
        .tlp_sop,
        .tlp_eop,
        .tlp_hdr,
        .tlp_payload,
        .rsp_valid,
        .rsp_ready,
        .rsp_data,
        .error
    );

    always #20 clk = ~clk;

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // 64-bit memory write, eight-byte lines are two dwords, all bytes enabled
    function automatic logic [63:0] expected_header(
        input logic [`WR_TLP_ADDR_W-1:0] addr,
        input logic [9:0]                len
    );
        logic [37:0] dw_addr;
        dw_addr = {addr[36:0], 1'b0};
        return {FMT_MWR64, len, 4'hf, 4'hf, dw_addr};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp)
        begin
            mismatches++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Model of the framing rules, run once over the table before traffic starts
    task automatic build_expected();
        logic [63:0]              hold_hdr;
        logic [`WR_TLP_TAG_W-1:0] hold_tag;
        int                       left;
        logic                     err_seen;
        exp_tlp_t                 beat;
        wr_rsp_t                  rsp;
        hold_hdr = '0;
        hold_tag = '0;
        left     = 0;
        err_seen = 1'b0;
        foreach (rows[i])
        begin
            if (rows[i].fence)
            begin
                // Fences make no TLP and answer with their own tag
                rsp.tag      = rows[i].tag;
                rsp.is_fence = 1'b1;
                exp_rsp_q.push_back(rsp);
            end
            else
            begin
                if (rows[i].sop)
                begin
                    hold_hdr = expected_header(rows[i].addr, rows[i].exp_len);
                    hold_tag = rows[i].tag;
                    left     = int'(rows[i].lcnt) + 1;
                end
                left--;
                // eop has to fall on the last announced line, and error never clears
                if (rows[i].eop != (left == 0))
                    err_seen = 1'b1;
                beat.sop     = rows[i].sop;
                beat.eop     = rows[i].eop;
                beat.hdr     = hold_hdr;
                beat.payload = rows[i].payload;
                beat.err     = err_seen;
                exp_tlp_q.push_back(beat);
                if (rows[i].eop)
                begin
                    rsp.tag      = hold_tag;
                    rsp.is_fence = 1'b0;
                    exp_rsp_q.push_back(rsp);
                end
            end
        end
    endtask

    // Holds one request on the bus until the handshake edge has passed
    task automatic send_request(input int i);
        req_data.sop        = rows[i].sop;
        req_data.eop        = rows[i].eop;
        req_data.is_fence   = rows[i].fence;
        req_data.tag        = rows[i].tag;
        req_data.line_count = rows[i].lcnt;
        req_data.addr       = rows[i].addr;
        req_data.payload    = rows[i].payload;
        req_valid           = 1'b1;
        @(negedge clk);
        while (!req_ready)
            @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    // Random ready levels, one LFSR step per bit taken
    always @(posedge clk)
    begin
        #1;
        lfsr      = lfsr_step(lfsr);
        tlp_ready = lfsr[0];
        lfsr      = lfsr_step(lfsr);
        rsp_ready = lfsr[0];
    end

    // Outputs are steady at the falling edge, so a handshake seen here
    // is the one that completes on the next rising edge
    always @(negedge clk)
    begin : output_monitor
        exp_tlp_t beat;
        wr_rsp_t  rsp;
        if (running && tlp_valid && tlp_ready)
        begin
            if (exp_tlp_q.size() == 0)
            begin
                other_errors++;
                $display("TLP beat at %0t ns was not expected, payload %h", $time, tlp_payload);
            end
            else
            begin
                beat = exp_tlp_q.pop_front();
                check_value("tlp_sop", 64'(tlp_sop), 64'(beat.sop));
                check_value("tlp_eop", 64'(tlp_eop), 64'(beat.eop));
                check_value("tlp_hdr", tlp_hdr, beat.hdr);
                check_value("tlp_payload", tlp_payload, beat.payload);
                check_value("error", 64'(error), 64'(beat.err));
            end
        end
        if (running && rsp_valid && rsp_ready)
        begin
            if (exp_rsp_q.size() == 0)
            begin
                other_errors++;
                $display("Response at %0t ns was not expected, tag %h", $time, rsp_data.tag);
            end
            else
            begin
                rsp = exp_rsp_q.pop_front();
                check_value("rsp_data.tag", 64'(rsp_data.tag), 64'(rsp.tag));
                check_value("rsp_data.is_fence", 64'(rsp_data.is_fence), 64'(rsp.is_fence));
            end
        end
    end

    // Watchdog sized from the table length
    always @(posedge clk)
    begin
        if (running)
        begin
            cycles++;
            if (cycles > cycle_limit)
            begin
                $display("Timeout after %0d cycles, %0d TLP beats and %0d responses never came",
                         cycles, exp_tlp_q.size(), exp_rsp_q.size());
                $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                         checks, mismatches, other_errors + 1);
                $display("=== FAIL ===");
                $finish;
            end
        end
    end

    initial
    begin
        clk          = 1'b0;
        reset_n      = 1'b0;
        req_valid    = 1'b0;
        req_data     = '0;
        tlp_ready    = 1'b0;
        rsp_ready    = 1'b0;
        lfsr         = 32'd92062;
        checks       = 0;
        mismatches   = 0;
        other_errors = 0;
        cycles       = 0;
        running      = 1'b0;
        fill_table();
        build_expected();
        cycle_limit = rows.size() * CYCLES_PER_ROW;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // Idle outputs right after reset
        @(negedge clk);
        check_value("tlp_valid", 64'(tlp_valid), 64'd0);
        check_value("rsp_valid", 64'(rsp_valid), 64'd0);
        check_value("error", 64'(error), 64'd0);
        check_value("req_ready", 64'(req_ready), 64'd1);
        running = 1'b1;

        @(posedge clk);
        #1;
        foreach (rows[i])
            send_request(i);
        req_valid = 1'b0;

        while (exp_tlp_q.size() != 0 || exp_rsp_q.size() != 0)
            @(negedge clk);
        // A few idle cycles catch any extra beat or response
        repeat (10) @(negedge clk);
        check_value("error", 64'(error), 64'd1);

        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+hw
+incdir+tb
hw/wr_tlp_pkg.sv
hw/req_fifo2.sv
hw/wr_hdr_builder.sv
hw/wr_beat_counter.sv
hw/wr_pkt_ctrl.sv
hw/wr_tlp_gen_top.sv
tb/wr_tlp_gen_tb.sv

//--- Makefile
# Verilator build and run for the write TLP generator testbench

SIM := obj_dir/Vwr_tlp_gen_tb
SOURCES := filelist.f $(wildcard hw/*.sv hw/*.svh tb/*.sv tb/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES)
	verilator --binary --timing -j 0 --top-module wr_tlp_gen_tb \
		-f filelist.f -o Vwr_tlp_gen_tb

# The run fails unless the testbench printed its pass line
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '=== PASS ==='

clean:
	rm -rf obj_dir
